//--- logic/lcdMenuPkg.sv
`default_nettype none

package lcdMenuPkg;

	localparam int codeLength = 9;	// digits in an access code

	localparam logic [7:0] charZero = 8'h30;
	localparam logic [7:0] charBlank = 8'h20;
	localparam logic [7:0] lineOneBase = 8'h80;	// set ddram address, line one
	localparam logic [7:0] lineTwoBase = 8'hC0;	// set ddram address, line two

	typedef enum logic [3:0] {
		screenIdle,
		screenMenu,
		screenTeacher,
		screenStudent,
		screenJobPrompt,
		screenStudentPrompt,
		screenEntry,
		screenMatch,
		screenNoMatch
	} menuScreen_t;

	typedef struct packed {
		logic turn;	// one cycle per detent
		logic left;	// direction, valid with turn
		logic press;	// one cycle per push
	} knobEvent_t;

	typedef logic [3:0] digit_t;

	typedef digit_t [0:codeLength-1] codeDigits_t;	// element 0 is leftmost

	typedef struct packed {
		logic isData;	// 0 command, 1 character
		logic [7:0] value;
	} lcdByte_t;

	typedef struct packed {
		logic line;
		logic [3:0] column;
	} cursorPos_t;

endpackage

`default_nettype wire

//--- logic/knobInput.sv
`timescale 1ns/1ns
`default_nettype none

module knobInput (
	input logic clk,
	input logic reset,
	input logic knobA,
	input logic knobB,
	input logic knobPush,
	output lcdMenuPkg::knobEvent_t knobEvent
);

	logic latchA;
	logic latchB;
	logic latchADly;
	logic pushSync;
	logic pushDly;
	logic aRise;

	assign aRise = latchA & ~latchADly;

	////////////////////
	// quadrature latches
	always_ff @(posedge clk) begin
		if (reset) begin
			latchA <= 1'b0;
			latchB <= 1'b0;
		end else begin
			case ({knobA, knobB})
				2'b00: latchA <= 1'b0;
				2'b11: latchA <= 1'b1;
				2'b01: latchB <= 1'b1;
				default: latchB <= 1'b0;	// 2'b10
			endcase
		end
	end

	////////////////////
	// event strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			latchADly <= 1'b0;
			pushSync <= 1'b0;
			pushDly <= 1'b0;
			knobEvent <= '0;
		end else begin
			latchADly <= latchA;
			pushSync <= knobPush;
			pushDly <= pushSync;
			knobEvent.turn <= aRise;
			knobEvent.press <= pushSync & ~pushDly;	// rising edge of push
			if (aRise)
				knobEvent.left <= latchB;	// B already high means turning left
		end
	end

endmodule

`default_nettype wire

//--- logic/menuControl.sv
`timescale 1ns/1ns
`default_nettype none

module menuControl #(
	parameter lcdMenuPkg::codeDigits_t accessCode = 36'h2_0148_4006
) (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::knobEvent_t knobEvent,
	input logic codeCheck,
	output lcdMenuPkg::menuScreen_t screen,
	output lcdMenuPkg::codeDigits_t digits
);

	logic [3:0] cursor;	// index of the digit being edited

	// left turn counts up, right turn counts down, both wrap
	function automatic lcdMenuPkg::digit_t stepDigit(input lcdMenuPkg::digit_t d,
		input logic up);
		if (up)
			return (d == 4'd9) ? 4'd0 : d + 4'd1;
		return (d == 4'd0) ? 4'd9 : d - 4'd1;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			screen <= lcdMenuPkg::screenIdle;
			digits <= '0;
			cursor <= '0;
		end else begin
			case (screen)
				lcdMenuPkg::screenIdle: begin
					if (knobEvent.turn)
						screen <= lcdMenuPkg::screenMenu;
				end
				lcdMenuPkg::screenMenu: begin
					if (knobEvent.turn)
						screen <= knobEvent.left ? lcdMenuPkg::screenTeacher
							: lcdMenuPkg::screenStudent;
					else if (knobEvent.press)
						screen <= lcdMenuPkg::screenIdle;
				end
				lcdMenuPkg::screenTeacher: begin
					if (knobEvent.turn) begin
						if (knobEvent.left)
							screen <= lcdMenuPkg::screenJobPrompt;
					end else if (knobEvent.press)
						screen <= lcdMenuPkg::screenMenu;
				end
				lcdMenuPkg::screenStudent: begin
					if (knobEvent.turn) begin
						if (!knobEvent.left)
							screen <= lcdMenuPkg::screenStudentPrompt;
					end else if (knobEvent.press)
						screen <= lcdMenuPkg::screenMenu;
				end
				lcdMenuPkg::screenJobPrompt: begin
					if (knobEvent.press)
						screen <= lcdMenuPkg::screenTeacher;
				end
				lcdMenuPkg::screenStudentPrompt: begin
					if (knobEvent.press)
						screen <= lcdMenuPkg::screenEntry;
				end
				lcdMenuPkg::screenEntry: begin
					if (knobEvent.turn)
						digits[cursor] <= stepDigit(digits[cursor], knobEvent.left);
					if (knobEvent.press)
						cursor <= (cursor == 4'(lcdMenuPkg::codeLength - 1)) ? 4'd0
							: cursor + 4'd1;
					if (codeCheck)	// compare uses the digits before this cycle's edit
						screen <= (digits == accessCode) ? lcdMenuPkg::screenMatch
							: lcdMenuPkg::screenNoMatch;
				end
				lcdMenuPkg::screenMatch, lcdMenuPkg::screenNoMatch: begin
					if (knobEvent.press)
						screen <= lcdMenuPkg::screenStudentPrompt;
				end
				default: screen <= lcdMenuPkg::screenIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/screenText.sv
`timescale 1ns/1ns
`default_nettype none

module screenText (
	input lcdMenuPkg::menuScreen_t screen,
	input lcdMenuPkg::codeDigits_t digits,
	input lcdMenuPkg::cursorPos_t position,
	output logic [7:0] character
);

	typedef logic [0:15][7:0] lineText_t;	// column 0 first

	localparam lineText_t blankLine = {16{lcdMenuPkg::charBlank}};

	////////////////////
	// fixed texts, padded to 16 columns
	localparam lineText_t idleTop = "welcome to the  ";
	localparam lineText_t idleBottom = "     system     ";
	localparam lineText_t menuTop = "1.entering      ";
	localparam lineText_t menuBottom = "2.inquire       ";
	localparam lineText_t roleTop = "1.teacher       ";
	localparam lineText_t roleBottom = "2.student       ";
	localparam lineText_t jobTop = "please input job";
	localparam lineText_t jobBottom = " number and name";
	localparam lineText_t studentTop = "please input    ";
	localparam lineText_t studentBottom = " student number ";
	localparam lineText_t matchTop = "code accepted   ";
	localparam lineText_t noMatchTop = "found no one    ";

	lineText_t topText;
	lineText_t bottomText;
	lineText_t lineText;
	logic digitsTop;
	logic digitsBottom;
	logic showDigits;
	logic [7:0] digitChar;

	always_comb begin
		topText = blankLine;
		bottomText = blankLine;
		digitsTop = 1'b0;
		digitsBottom = 1'b0;
		case (screen)
			lcdMenuPkg::screenIdle: begin
				topText = idleTop;
				bottomText = idleBottom;
			end
			lcdMenuPkg::screenMenu: begin
				topText = menuTop;
				bottomText = menuBottom;
			end
			lcdMenuPkg::screenTeacher, lcdMenuPkg::screenStudent: begin
				topText = roleTop;
				bottomText = roleBottom;
			end
			lcdMenuPkg::screenJobPrompt: begin
				topText = jobTop;
				bottomText = jobBottom;
			end
			lcdMenuPkg::screenStudentPrompt: begin
				topText = studentTop;
				bottomText = studentBottom;
			end
			lcdMenuPkg::screenEntry: digitsTop = 1'b1;
			lcdMenuPkg::screenMatch: begin
				topText = matchTop;
				digitsBottom = 1'b1;	// echo the accepted code
			end
			lcdMenuPkg::screenNoMatch: topText = noMatchTop;
			default: topText = blankLine;
		endcase
	end

	// digits sit in columns 0 to 8, the rest of the line is blank
	always_comb begin
		digitChar = lcdMenuPkg::charBlank;
		if (position.column < 4'(lcdMenuPkg::codeLength))
			digitChar = lcdMenuPkg::charZero + {4'h0, digits[position.column]};
	end

	assign lineText = position.line ? bottomText : topText;
	assign showDigits = position.line ? digitsBottom : digitsTop;
	assign character = showDigits ? digitChar : lineText[position.column];

endmodule

`default_nettype wire

//--- logic/screenRefresh.sv
`timescale 1ns/1ns
`default_nettype none

module screenRefresh #(
	parameter int clearCycles = 82000
) (
	input logic clk,
	input logic reset,
	input logic busReady,
	input logic busy,
	output lcdMenuPkg::cursorPos_t position,
	input logic [7:0] character,
	output lcdMenuPkg::lcdByte_t lcdByte,
	output logic byteSend
);

	localparam int waitWidth = $clog2(clearCycles + 1);
	localparam logic [0:3][7:0] setupCmds = {8'h28, 8'h06, 8'h0C, 8'h01};

	typedef enum logic [1:0] {stSetup, stClearWait, stAddress, stChar} refreshState_t;

	refreshState_t state;
	logic [1:0] setupIndex;
	logic [waitWidth-1:0] waitCount;
	logic [7:0] lineBase;

	assign lineBase = position.line ? lcdMenuPkg::lineTwoBase : lcdMenuPkg::lineOneBase;
	assign byteSend = busReady && !busy && (state != stClearWait);	// bus takes it this edge

	always_comb begin
		case (state)
			stSetup: lcdByte = '{isData: 1'b0, value: setupCmds[setupIndex]};
			stAddress: lcdByte = '{isData: 1'b0, value: lineBase + {4'h0, position.column}};
			stChar: lcdByte = '{isData: 1'b1, value: character};
			default: lcdByte = '{isData: 1'b0, value: 8'h00};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stSetup;
			setupIndex <= 2'd0;
			waitCount <= '0;
			position <= '0;
		end else begin
			case (state)
				stSetup: begin
					if (byteSend) begin
						if (setupIndex == 2'd3) begin	// clear just went out
							state <= stClearWait;
							waitCount <= waitWidth'(clearCycles - 1);
						end else
							setupIndex <= setupIndex + 2'd1;
					end
				end
				stClearWait: begin
					if (!busy) begin	// count once the clear byte is finished
						if (waitCount == '0)
							state <= stAddress;
						else
							waitCount <= waitCount - 1'b1;
					end
				end
				stAddress: begin
					if (byteSend)
						state <= stChar;
				end
				default: begin
					if (byteSend) begin
						state <= stAddress;
						position <= lcdMenuPkg::cursorPos_t'(position + 5'd1);	// wraps at 32
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/lcdNibbleBus.sv
`timescale 1ns/1ns
`default_nettype none

module lcdNibbleBus #(
	parameter int powerUpCycles = 750000,
	parameter int longWaitCycles = 205000,
	parameter int shortWaitCycles = 5000,
	parameter int gapCycles = 2000,
	parameter int enableCycles = 12
) (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::lcdByte_t lcdByte,
	input logic byteSend,
	output logic busReady,
	output logic busy,
	output logic lcdE,
	output logic lcdRs,
	output logic lcdRw,
	output logic [3:0] lcdData
);

	// sum is always wide enough for the longest wait
	localparam int countWidth = $clog2(powerUpCycles + longWaitCycles + shortWaitCycles
		+ gapCycles + enableCycles + 1);

	typedef enum logic [3:0] {
		stPowerUp, stInitLoad, stInitSet, stInitHold, stInitWait,
		stIdle, stHiSet, stHiHold, stLoLoad, stLoSet, stLoHold, stGap
	} busState_t;

	busState_t state;
	logic [countWidth-1:0] count;
	logic [1:0] initStep;	// which of the four power-up nibbles
	logic [countWidth-1:0] initWait;
	logic [3:0] lowNibble;

	assign lcdRw = 1'b0;	// write only

	always_comb begin
		case (initStep)
			2'd0: initWait = countWidth'(longWaitCycles - 1);
			2'd1: initWait = countWidth'(shortWaitCycles - 1);
			default: initWait = countWidth'(gapCycles - 1);
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stPowerUp;
			count <= countWidth'(powerUpCycles - 1);
			initStep <= 2'd0;
			busReady <= 1'b0;
			busy <= 1'b0;
			lcdE <= 1'b0;
			lcdRs <= 1'b0;
			lcdData <= 4'h0;
			lowNibble <= 4'h0;
		end else begin
			case (state)
				////////////////////
				// power-up nibbles 3, 3, 3, 2
				stPowerUp: begin
					if (count == '0)
						state <= stInitLoad;
					else
						count <= count - 1'b1;
				end
				stInitLoad: begin
					lcdData <= (initStep == 2'd3) ? 4'h2 : 4'h3;
					state <= stInitSet;
				end
				stInitSet: begin
					lcdE <= 1'b1;
					count <= countWidth'(enableCycles - 1);
					state <= stInitHold;
				end
				stInitHold: begin
					if (count == '0) begin
						lcdE <= 1'b0;
						count <= initWait;
						state <= stInitWait;
					end else
						count <= count - 1'b1;
				end
				stInitWait: begin
					if (count != '0)
						count <= count - 1'b1;
					else if (initStep == 2'd3) begin
						busReady <= 1'b1;
						state <= stIdle;
					end else begin
						initStep <= initStep + 2'd1;
						state <= stInitLoad;
					end
				end
				////////////////////
				// byte as two nibbles
				stIdle: begin
					if (byteSend) begin
						lcdData <= lcdByte.value[7:4];	// high nibble first
						lowNibble <= lcdByte.value[3:0];
						lcdRs <= lcdByte.isData;
						busy <= 1'b1;
						state <= stHiSet;
					end
				end
				stHiSet, stLoSet: begin
					lcdE <= 1'b1;
					count <= countWidth'(enableCycles - 1);
					state <= (state == stHiSet) ? stHiHold : stLoHold;
				end
				stHiHold: begin
					if (count == '0) begin
						lcdE <= 1'b0;
						state <= stLoLoad;
					end else
						count <= count - 1'b1;
				end
				stLoLoad: begin
					lcdData <= lowNibble;	// e has been low a full cycle
					state <= stLoSet;
				end
				stLoHold: begin
					if (count == '0) begin
						lcdE <= 1'b0;
						count <= countWidth'(gapCycles - 1);
						state <= stGap;
					end else
						count <= count - 1'b1;
				end
				stGap: begin
					if (count == '0) begin
						busy <= 1'b0;
						state <= stIdle;
					end else
						count <= count - 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/lcdMenuTop.sv
`timescale 1ns/1ns
`default_nettype none

module lcdMenuTop #(
	parameter int powerUpCycles = 750000,	// 15 ms at 50 MHz
	parameter int longWaitCycles = 205000,
	parameter int shortWaitCycles = 5000,
	parameter int gapCycles = 2000,
	parameter int enableCycles = 12,
	parameter int clearCycles = 82000,
	parameter lcdMenuPkg::codeDigits_t accessCode = 36'h2_0148_4006
) (
	input logic clk,
	input logic reset,
	input logic knobA,
	input logic knobB,
	input logic knobPush,
	input logic codeCheck,
	output logic lcdE,
	output logic lcdRs,
	output logic lcdRw,
	output logic [3:0] lcdData
);

	lcdMenuPkg::knobEvent_t knobEvent;
	lcdMenuPkg::menuScreen_t screen;
	lcdMenuPkg::codeDigits_t digits;
	lcdMenuPkg::cursorPos_t position;
	lcdMenuPkg::lcdByte_t lcdByte;
	logic [7:0] character;
	logic byteSend;
	logic busReady;
	logic busy;

	knobInput knobInputInst (
		.clk(clk),
		.reset(reset),
		.knobA(knobA),
		.knobB(knobB),
		.knobPush(knobPush),
		.knobEvent(knobEvent)
	);

	menuControl #(
		.accessCode(accessCode)
	) menuControlInst (
		.clk(clk),
		.reset(reset),
		.knobEvent(knobEvent),
		.codeCheck(codeCheck),
		.screen(screen),
		.digits(digits)
	);

	screenText screenTextInst (
		.screen(screen),
		.digits(digits),
		.position(position),
		.character(character)
	);

	screenRefresh #(
		.clearCycles(clearCycles)
	) screenRefreshInst (
		.clk(clk),
		.reset(reset),
		.busReady(busReady),
		.busy(busy),
		.position(position),
		.character(character),
		.lcdByte(lcdByte),
		.byteSend(byteSend)
	);

	lcdNibbleBus #(
		.powerUpCycles(powerUpCycles),
		.longWaitCycles(longWaitCycles),
		.shortWaitCycles(shortWaitCycles),
		.gapCycles(gapCycles),
		.enableCycles(enableCycles)
	) lcdNibbleBusInst (
		.clk(clk),
		.reset(reset),
		.lcdByte(lcdByte),
		.byteSend(byteSend),
		.busReady(busReady),
		.busy(busy),
		.lcdE(lcdE),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdData(lcdData)
	);

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int halfPeriod = 2,	// 4 ns period
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;	// released just after an edge
	end

endmodule

`default_nettype wire

//--- bench/lcdMenuBench.sv
`timescale 1ns/1ns
`default_nettype none

module lcdMenuBench;

	typedef enum logic [2:0] {actNone, actTurnLeft, actTurnRight, actPress, actCheck} action_t;

	typedef struct packed {
		action_t action;
		logic [3:0] count;	// 0 picks a random count 1 to 9
		lcdMenuPkg::menuScreen_t screen;
	} stimRow_t;

	localparam int rowCount = 33;
	localparam int passTimeout = 6000;
	localparam logic [7:0] setupExpected [0:3] = '{8'h28, 8'h06, 8'h0C, 8'h01};

	stimRow_t stimTable [0:rowCount-1] = '{
		'{actNone, 4'd1, lcdMenuPkg::screenIdle},
		'{actTurnRight, 4'd1, lcdMenuPkg::screenMenu},
		'{actTurnLeft, 4'd1, lcdMenuPkg::screenTeacher},
		'{actTurnLeft, 4'd1, lcdMenuPkg::screenJobPrompt},
		'{actPress, 4'd1, lcdMenuPkg::screenTeacher},
		'{actPress, 4'd1, lcdMenuPkg::screenMenu},
		'{actTurnRight, 4'd1, lcdMenuPkg::screenStudent},
		'{actTurnRight, 4'd1, lcdMenuPkg::screenStudentPrompt},
		'{actPress, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnRight, 4'd1, lcdMenuPkg::screenEntry},	// 0 wraps to 9
		'{actTurnLeft, 4'd1, lcdMenuPkg::screenEntry},	// 9 wraps to 0
		'{actTurnLeft, 4'd2, lcdMenuPkg::screenEntry},
		'{actPress, 4'd9, lcdMenuPkg::screenEntry},	// cursor comes back to first digit
		'{actTurnLeft, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnRight, 4'd1, lcdMenuPkg::screenEntry},
		'{actPress, 4'd2, lcdMenuPkg::screenEntry},
		'{actTurnLeft, 4'd1, lcdMenuPkg::screenEntry},
		'{actPress, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnLeft, 4'd4, lcdMenuPkg::screenEntry},
		'{actPress, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnRight, 4'd2, lcdMenuPkg::screenEntry},
		'{actPress, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnLeft, 4'd4, lcdMenuPkg::screenEntry},
		'{actPress, 4'd3, lcdMenuPkg::screenEntry},
		'{actTurnLeft, 4'd6, lcdMenuPkg::screenEntry},	// code now 201484006
		'{actCheck, 4'd1, lcdMenuPkg::screenMatch},
		'{actPress, 4'd1, lcdMenuPkg::screenStudentPrompt},
		'{actPress, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnLeft, 4'd0, lcdMenuPkg::screenEntry},	// last digit no longer matches
		'{actPress, 4'd1, lcdMenuPkg::screenEntry},
		'{actTurnLeft, 4'd0, lcdMenuPkg::screenEntry},
		'{actCheck, 4'd1, lcdMenuPkg::screenNoMatch},
		'{actPress, 4'd1, lcdMenuPkg::screenStudentPrompt}
	};

	logic clk;
	logic reset;
	logic knobA;
	logic knobB;
	logic knobPush;
	logic codeCheck;
	logic lcdE;
	logic lcdRs;
	logic lcdRw;
	logic [3:0] lcdData;

	integer seed = 32'h5408_b59b;

	// shadow of the display built from the bus
	logic [7:0] shadow [0:1][0:15];
	logic shadowLine = 1'b0;
	logic [3:0] shadowCol = 4'd0;
	int nibbleCount = 0;
	int byteCount = 0;
	int dataCount = 0;
	logic haveHigh = 1'b0;
	logic [3:0] highNibble = 4'h0;
	lcdMenuPkg::lcdByte_t setupBytes [0:3];
	logic prevE = 1'b0;
	logic [3:0] prevData = 4'h0;

	// expected state
	lcdMenuPkg::menuScreen_t modelScreen;
	lcdMenuPkg::codeDigits_t modelDigits;
	int modelCursor;

	clockGen clockGenInst (
		.clk(clk),
		.reset(reset)
	);

	lcdMenuTop #(
		.powerUpCycles(40),
		.longWaitCycles(20),
		.shortWaitCycles(10),
		.gapCycles(6),
		.enableCycles(3),
		.clearCycles(12)
	) lcdMenuTop_inst (
		.clk(clk),
		.reset(reset),
		.knobA(knobA),
		.knobB(knobB),
		.knobPush(knobPush),
		.codeCheck(codeCheck),
		.lcdE(lcdE),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdData(lcdData)
	);

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	////////////////////
	// bus decoder
	always @(negedge lcdE) begin
		logic [7:0] byteValue;
		if (reset === 1'b0) begin
			if (nibbleCount < 4) begin
				nibbleCount = nibbleCount + 1;	// power-up nibbles
			end else if (!haveHigh) begin
				highNibble = lcdData;
				haveHigh = 1'b1;
			end else begin
				byteValue = {highNibble, lcdData};
				haveHigh = 1'b0;
				if (byteCount < 4)
					setupBytes[byteCount] = '{isData: lcdRs, value: byteValue};
				byteCount = byteCount + 1;
				if (lcdRs) begin
					shadow[shadowLine][shadowCol] = byteValue;
					shadowCol = shadowCol + 4'd1;	// entry mode increments
					dataCount = dataCount + 1;
				end else if (byteValue >= 8'h80) begin
					shadowLine = byteValue[6];
					shadowCol = byteValue[3:0];
				end
			end
		end
	end

	// rw held low, data stable around the enable pulse
	always @(posedge clk) begin
		#1;
		if (reset === 1'b0) begin
			if (lcdRw !== 1'b0)
				reportFailure($sformatf("error lcdRw expected %h got %h", 1'b0, lcdRw));
			if ((prevE || lcdE) && lcdData !== prevData)
				reportFailure($sformatf("error lcdData changed while lcdE high, was %h now %h",
					prevData, lcdData));
		end
		prevE = lcdE;
		prevData = lcdData;
	end

	////////////////////
	// screen model
	function automatic logic digitPosition(input lcdMenuPkg::menuScreen_t s, input int line,
		input int col);
		return col < lcdMenuPkg::codeLength && ((s == lcdMenuPkg::screenEntry && line == 0)
			|| (s == lcdMenuPkg::screenMatch && line == 1));
	endfunction

	function automatic logic [7:0] expectedChar(input lcdMenuPkg::menuScreen_t s,
		input lcdMenuPkg::codeDigits_t d, input int line, input int col);
		string top;
		string bottom;
		string text;
		string digitText;
		top = "";
		bottom = "";
		digitText = "0123456789";
		if (digitPosition(s, line, col))
			return digitText[int'(d[col])];
		case (s)
			lcdMenuPkg::screenIdle: begin
				top = "welcome to the";
				bottom = "     system";
			end
			lcdMenuPkg::screenMenu: begin
				top = "1.entering";
				bottom = "2.inquire";
			end
			lcdMenuPkg::screenTeacher, lcdMenuPkg::screenStudent: begin
				top = "1.teacher";
				bottom = "2.student";
			end
			lcdMenuPkg::screenJobPrompt: begin
				top = "please input job";
				bottom = " number and name";
			end
			lcdMenuPkg::screenStudentPrompt: begin
				top = "please input";
				bottom = " student number";
			end
			lcdMenuPkg::screenMatch: top = "code accepted";
			lcdMenuPkg::screenNoMatch: top = "found no one";
			default: top = "";
		endcase
		text = (line == 0) ? top : bottom;
		if (col < text.len())
			return text[col];
		return lcdMenuPkg::charBlank;
	endfunction

	function automatic logic textMatches(input lcdMenuPkg::menuScreen_t s, input int line);
		logic [7:0] ch;
		for (int col = 0; col < 16; col++) begin
			ch = shadow[line][col];
			if (digitPosition(s, line, col)) begin
				if (ch < lcdMenuPkg::charZero || ch > lcdMenuPkg::charZero + 8'd9)
					return 1'b0;
			end else if (ch !== expectedChar(s, '0, line, col))
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// teacher stands for student too since both show the same text
	function automatic lcdMenuPkg::menuScreen_t inferScreen();
		lcdMenuPkg::menuScreen_t s;
		for (int i = 0; i < 9; i++) begin
			s = lcdMenuPkg::menuScreen_t'(4'(i));
			if (s != lcdMenuPkg::screenStudent && textMatches(s, 0) && textMatches(s, 1))
				return s;
		end
		return lcdMenuPkg::menuScreen_t'(4'hF);	// fits no screen
	endfunction

	function automatic lcdMenuPkg::codeDigits_t inferDigits(input int line);
		lcdMenuPkg::codeDigits_t d;
		for (int i = 0; i < lcdMenuPkg::codeLength; i++)
			d[i] = 4'(shadow[line][i] - lcdMenuPkg::charZero);
		return d;
	endfunction

	////////////////////
	// compare tasks
	task automatic checkScreen(input lcdMenuPkg::menuScreen_t expected,
		input lcdMenuPkg::menuScreen_t actual);
		if (actual !== expected)
			reportFailure($sformatf("error screen expected %h got %h", expected, actual));
	endtask

	task automatic checkChar(input int line, input int col, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("error shadow[%0d][%0d] expected %h got %h", line, col,
				expected, actual));
	endtask

	task automatic checkDigits(input lcdMenuPkg::codeDigits_t expected,
		input lcdMenuPkg::codeDigits_t actual);
		if (actual !== expected)
			reportFailure($sformatf("error digits expected %h got %h", expected, actual));
	endtask

	task automatic checkSetupByte(input int index, input lcdMenuPkg::lcdByte_t expected,
		input lcdMenuPkg::lcdByte_t actual);
		if (actual !== expected)
			reportFailure($sformatf("error setupBytes[%0d] expected %h got %h", index,
				expected, actual));
	endtask

	task automatic compareShadow();
		lcdMenuPkg::menuScreen_t shown;
		shown = (modelScreen == lcdMenuPkg::screenStudent) ? lcdMenuPkg::screenTeacher
			: modelScreen;
		checkScreen(shown, inferScreen());
		if (modelScreen == lcdMenuPkg::screenEntry)
			checkDigits(modelDigits, inferDigits(0));
		else if (modelScreen == lcdMenuPkg::screenMatch)
			checkDigits(modelDigits, inferDigits(1));
		for (int line = 0; line < 2; line++)
			for (int col = 0; col < 16; col++)
				checkChar(line, col, expectedChar(modelScreen, modelDigits, line, col),
					shadow[line][col]);
	endtask

	////////////////////
	// stimulus
	task automatic holdLevels(input logic a, input logic b);
		knobA = a;
		knobB = b;
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic turnKnob(input logic left);
		holdLevels(1'b0, 1'b0);
		if (left) begin
			holdLevels(1'b0, 1'b1);
			holdLevels(1'b1, 1'b1);
			holdLevels(1'b1, 1'b0);
		end else begin
			holdLevels(1'b1, 1'b0);
			holdLevels(1'b1, 1'b1);
			holdLevels(1'b0, 1'b1);
		end
		holdLevels(1'b0, 1'b0);
	endtask

	task automatic pushButton();
		knobPush = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		knobPush = 1'b0;
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic pulseCheck();
		codeCheck = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		codeCheck = 1'b0;
		repeat (3) @(posedge clk);
		#1;
	endtask

	// one action and its effect on the digit model
	task automatic applyAction(input action_t action);
		int d;
		d = int'(modelDigits[modelCursor]);
		case (action)
			actTurnLeft: begin
				turnKnob(1'b1);
				if (modelScreen == lcdMenuPkg::screenEntry)
					modelDigits[modelCursor] = 4'((d + 1) % 10);
			end
			actTurnRight: begin
				turnKnob(1'b0);
				if (modelScreen == lcdMenuPkg::screenEntry)
					modelDigits[modelCursor] = 4'((d + 9) % 10);
			end
			actPress: begin
				pushButton();
				if (modelScreen == lcdMenuPkg::screenEntry)
					modelCursor = (modelCursor + 1) % lcdMenuPkg::codeLength;
			end
			actCheck: pulseCheck();
			default: ;
		endcase
	endtask

	// two full passes so every position is rewritten after the change
	task automatic waitPasses();
		int target;
		int cycles;
		target = dataCount + 64;
		cycles = 0;
		while (dataCount < target) begin
			@(posedge clk);
			#1;
			cycles = cycles + 1;
			if (cycles > passTimeout)
				reportFailure("timeout while waiting for the display refresh passes");
		end
	endtask

	initial begin
		int cycles;
		int reps;
		stimRow_t row;
		knobA = 1'b0;
		knobB = 1'b0;
		knobPush = 1'b0;
		codeCheck = 1'b0;
		for (int line = 0; line < 2; line++)
			for (int col = 0; col < 16; col++)
				shadow[line][col] = lcdMenuPkg::charBlank;
		modelScreen = lcdMenuPkg::screenIdle;
		modelDigits = '0;
		modelCursor = 0;

		cycles = 0;
		while (reset !== 1'b0) begin
			@(negedge clk);
			cycles = cycles + 1;
			if (cycles > 20)
				reportFailure("timeout while waiting for reset to be released");
		end
		@(posedge clk);
		#1;

		// controller setup commands
		cycles = 0;
		while (byteCount < 4) begin
			@(posedge clk);
			#1;
			cycles = cycles + 1;
			if (cycles > 2000)
				reportFailure("timeout while waiting for the setup commands");
		end
		for (int i = 0; i < 4; i++)
			checkSetupByte(i, '{isData: 1'b0, value: setupExpected[i]}, setupBytes[i]);

		for (int r = 0; r < rowCount; r++) begin
			row = stimTable[r];
			reps = (row.count == 4'd0) ? 1 + int'($unsigned($random(seed)) % 9)
				: int'(row.count);
			for (int k = 0; k < reps; k++)
				applyAction(row.action);
			modelScreen = row.screen;
			waitPasses();
			compareShadow();
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/lcdMenuPkg.sv
logic/knobInput.sv
logic/menuControl.sv
logic/screenText.sv
logic/screenRefresh.sv
logic/lcdNibbleBus.sv
logic/lcdMenuTop.sv
bench/clockGen.sv
bench/lcdMenuBench.sv

//--- run.sh
#!/bin/sh
# build and run the LCD menu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal -f src.f --top-module lcdMenuBench -o simv

# the simulator's exit status is lost in the pipe, the log decides
./obj_dir/simv | tee sim.log
grep -q "Result: PASSED" sim.log
